// ==== hw/decode_if.sv ====
`timescale 1ns/1ns

// one decoded instruction, decoder to execute stage
interface decode_if import rv_pkg::*; ();

    logic      valid;   // fields below only meaningful with valid
    alu_op_t   alu_op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    logic      use_imm; // imm replaces rs2 as operand b

    modport src (
        output valid, alu_op, rs1, rs2, rd, imm, use_imm
    );

    modport dst (
        input valid, alu_op, rs1, rs2, rd, imm, use_imm
    );

endinterface

// ==== hw/reg_file.sv ====
`timescale 1ns/1ns

module reg_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      we,
    input  reg_addr_t rd_addr,
    input  word_t     rd_data
);

    word_t regs [num_regs];

    // x0 is never written, so it stays at its reset value of zero
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // async read
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

// ==== hw/rv_alu.sv ====
`timescale 1ns/1ns

module rv_alu import rv_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt = b[4:0]; // upper bits ignored

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu: result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $signed(a) >>> shamt; // sign fill
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            alu_pass: result = b;
            default:  result = '0;
        endcase
    end

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/1ns

module rv_core import rv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      instr_valid,
    input  word_t     instr,
    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output word_t     wb_data
);

    // decoded instruction, one stage deep
    decode_if dec_bus ();

    rv_decoder rv_decoder_inst (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dec         (dec_bus.src)
    );

    // reg read, alu, write-back
    rv_execute rv_execute_inst (
        .clk      (clk),
        .reset    (reset),
        .dec      (dec_bus.dst),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

// ==== hw/rv_decoder.sv ====
`timescale 1ns/1ns

module rv_decoder import rv_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  instr_valid,
    input  word_t instr,
    decode_if.src dec
);

    opcode_t   opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm_i;
    word_t     imm_u;

    alu_op_t   op_sel;
    logic      use_imm;
    word_t     imm;
    logic      legal;

    // field split
    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'd0};

    // control table
    always_comb begin
        legal   = 1'b1;
        op_sel  = alu_add;
        use_imm = 1'b1;
        imm     = imm_i;

        case (opcode)
            op_reg: begin
                use_imm = 1'b0;
                // alt funct7 only valid for sub and sra
                legal = (funct7 == f7_base) ||
                        (funct7 == f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
                case (funct3)
                    3'b000:  op_sel = (funct7 == f7_alt) ? alu_sub : alu_add;
                    3'b001:  op_sel = alu_sll;
                    3'b010:  op_sel = alu_slt;
                    3'b011:  op_sel = alu_sltu;
                    3'b100:  op_sel = alu_xor;
                    3'b101:  op_sel = (funct7 == f7_alt) ? alu_sra : alu_srl;
                    3'b110:  op_sel = alu_or;
                    default: op_sel = alu_and;
                endcase
            end

            op_imm: begin
                case (funct3)
                    3'b000: op_sel = alu_add;
                    3'b001: begin
                        op_sel = alu_sll;
                        legal  = (funct7 == f7_base);
                    end
                    3'b010: op_sel = alu_slt;
                    3'b011: op_sel = alu_sltu;
                    3'b100: op_sel = alu_xor;
                    3'b101: begin
                        // shamt sits in imm[4:0], funct7 picks the flavour
                        op_sel = (funct7 == f7_alt) ? alu_sra : alu_srl;
                        legal  = (funct7 == f7_base) || (funct7 == f7_alt);
                    end
                    3'b110:  op_sel = alu_or;
                    default: op_sel = alu_and;
                endcase
            end

            op_lui: begin
                op_sel = alu_pass;
                imm    = imm_u;
            end

            default: begin
                legal = 1'b0; // unknown opcode, dropped
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= instr_valid && legal;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            dec.alu_op  <= op_sel;
            dec.rs1     <= rs1;
            dec.rs2     <= rs2;
            dec.rd      <= rd;
            dec.imm     <= imm;
            dec.use_imm <= use_imm;
        end
    end

endmodule

// ==== hw/rv_execute.sv ====
`timescale 1ns/1ns

module rv_execute import rv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    decode_if.dst     dec,
    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output word_t     wb_data
);

    logic      ex_valid;
    alu_op_t   ex_op;
    reg_addr_t ex_rs1;
    reg_addr_t ex_rs2;
    reg_addr_t ex_rd;
    word_t     ex_imm;
    logic      ex_use_imm;

    word_t     rs1_data;
    word_t     rs2_data;
    word_t     operand_b;
    word_t     alu_result;

    // capture the decoded instruction
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ex_valid <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            ex_valid <= dec.valid;
            wb_valid <= ex_valid; // strobe rises with the reg write
        end
    end

    always_ff @(posedge clk) begin
        if (dec.valid) begin
            ex_op      <= dec.alu_op;
            ex_rs1     <= dec.rs1;
            ex_rs2     <= dec.rs2;
            ex_rd      <= dec.rd;
            ex_imm     <= dec.imm;
            ex_use_imm <= dec.use_imm;
        end
        if (ex_valid) begin
            wb_rd   <= ex_rd;
            wb_data <= alu_result;
        end
    end

    // read happens a cycle after capture, so a write from the
    // previous instruction has already landed, no forwarding needed
    reg_file reg_file_inst (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (ex_rs1),
        .rs2_addr (ex_rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (ex_valid),
        .rd_addr  (ex_rd),
        .rd_data  (alu_result)
    );

    assign operand_b = ex_use_imm ? ex_imm : rs2_data;

    rv_alu rv_alu_inst (
        .a      (rs1_data),
        .b      (operand_b),
        .op     (ex_op),
        .result (alu_result)
    );

endmodule

// ==== hw/rv_pkg.sv ====
package rv_pkg;

    // datapath widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;

    // funct7 values seen by the kept instructions
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000; // sub, sra, srai

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        op_imm = 7'b0010011,
        op_reg = 7'b0110011,
        op_lui = 7'b0110111
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9,
        alu_pass = 4'd10 // b straight through, lui
    } alu_op_t;

endpackage

// ==== sim.f ====
hw/rv_pkg.sv
hw/decode_if.sv
hw/rv_alu.sv
hw/reg_file.sv
hw/rv_decoder.sv
hw/rv_execute.sv
hw/rv_core.sv
verif/tb_clock.sv
verif/rv_core_tb.sv

// ==== verif/rv_core_tb.sv ====
`timescale 1ns/1ns

module rv_core_tb import rv_pkg::*; ();

    logic      clk;
    logic      reset;
    logic      instr_valid;
    word_t     instr;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;

    // stimulus table with one entry per row
    word_t     row_instr[$];
    bit        row_has_result[$];
    reg_addr_t row_rd[$];
    word_t     row_data[$];
    bit        row_b2b[$];   // issue in the cycle right after the previous row

    int due_q[$];            // cycle at which the strobe should be seen
    int idx_q[$];
    int cyc = 0;
    int errors = 0;
    int rows_passed = 0;
    int rows_failed = 0;

    tb_clock clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    rv_core rv_core_inst (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    always @(posedge clk) cyc <= cyc + 1;

    function automatic word_t encode_r(input logic [6:0] f7, input reg_addr_t rs2,
                                       input reg_addr_t rs1, input logic [2:0] f3,
                                       input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic word_t encode_i(input logic [11:0] imm, input reg_addr_t rs1,
                                       input logic [2:0] f3, input reg_addr_t rd,
                                       input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t encode_u(input logic [19:0] imm, input reg_addr_t rd);
        return {imm, rd, op_lui};
    endfunction

    task automatic add_row(input word_t ins, input bit has_result, input reg_addr_t rd,
                           input word_t data, input bit b2b);
        row_instr.push_back(ins);
        row_has_result.push_back(has_result);
        row_rd.push_back(rd);
        row_data.push_back(data);
        row_b2b.push_back(b2b);
    endtask

    task automatic fill_table();
        // constants via lui/addi and then the I-type group
        add_row(encode_u(20'h12345, 1), 1, 1, 32'h12345000, 0);
        add_row(encode_i(12'h678, 1, 3'b000, 1, op_imm), 1, 1, 32'h12345678, 0);
        add_row(encode_u(20'hdeadc, 2), 1, 2, 32'hdeadc000, 0);
        add_row(encode_i(12'heef, 2, 3'b000, 2, op_imm), 1, 2, 32'hdeadbeef, 0);
        add_row(encode_i(12'hffb, 0, 3'b000, 3, op_imm), 1, 3, 32'hfffffffb, 0);
        add_row(encode_i(12'h0ff, 1, 3'b100, 4, op_imm), 1, 4, 32'h12345687, 0);
        add_row(encode_i(12'hf00, 1, 3'b110, 5, op_imm), 1, 5, 32'hffffff78, 0);
        add_row(encode_i(12'h7f0, 2, 3'b111, 6, op_imm), 1, 6, 32'h000006e0, 0);
        add_row(encode_i(12'hfff, 1, 3'b010, 7, op_imm), 1, 7, 32'h00000000, 0); // slti
        add_row(encode_i(12'hfff, 1, 3'b011, 8, op_imm), 1, 8, 32'h00000001, 0); // sltiu
        add_row(encode_i(12'h002, 3, 3'b010, 30, op_imm), 1, 30, 32'h00000001, 0);
        // R-type group on x1 and x2
        add_row(encode_r(7'h00, 2, 1, 3'b000, 9), 1, 9, 32'hf0e21567, 0);
        add_row(encode_r(7'h20, 2, 1, 3'b000, 10), 1, 10, 32'h33869789, 0);
        add_row(encode_r(7'h00, 2, 1, 3'b100, 11), 1, 11, 32'hcc99e897, 0);
        add_row(encode_r(7'h00, 2, 1, 3'b110, 12), 1, 12, 32'hdebdfeff, 0);
        add_row(encode_r(7'h00, 2, 1, 3'b111, 13), 1, 13, 32'h12241668, 0);
        add_row(encode_r(7'h00, 1, 2, 3'b010, 14), 1, 14, 32'h00000001, 0); // slt
        add_row(encode_r(7'h00, 1, 2, 3'b011, 15), 1, 15, 32'h00000000, 0); // sltu
        // shift amount 0x7e4 where only the low five bits (4) count
        add_row(encode_i(12'h7e4, 0, 3'b000, 16, op_imm), 1, 16, 32'h000007e4, 0);
        add_row(encode_r(7'h00, 16, 2, 3'b001, 17), 1, 17, 32'headbeef0, 0);
        add_row(encode_r(7'h00, 16, 2, 3'b101, 18), 1, 18, 32'h0deadbee, 0);
        add_row(encode_r(7'h20, 16, 2, 3'b101, 19), 1, 19, 32'hfdeadbee, 0);
        add_row(encode_r(7'h20, 16, 1, 3'b101, 23), 1, 23, 32'h01234567, 0);
        add_row(encode_i(12'h004, 2, 3'b001, 20, op_imm), 1, 20, 32'headbeef0, 0);
        add_row(encode_i(12'h004, 2, 3'b101, 21, op_imm), 1, 21, 32'h0deadbee, 0);
        add_row(encode_i(12'h404, 2, 3'b101, 22, op_imm), 1, 22, 32'hfdeadbee, 0);
        // dependent chain with one issue per cycle
        add_row(encode_i(12'h001, 0, 3'b000, 24, op_imm), 1, 24, 32'h00000001, 0);
        add_row(encode_r(7'h00, 24, 24, 3'b000, 24), 1, 24, 32'h00000002, 1);
        add_row(encode_r(7'h00, 24, 24, 3'b000, 24), 1, 24, 32'h00000004, 1);
        add_row(encode_i(12'h008, 24, 3'b001, 25, op_imm), 1, 25, 32'h00000400, 1);
        add_row(encode_r(7'h20, 24, 25, 3'b000, 26), 1, 26, 32'h000003fc, 1);
        // x0 target strobes but stays zero
        add_row(encode_i(12'h123, 1, 3'b000, 0, op_imm), 1, 0, 32'h1234579b, 0);
        add_row(encode_r(7'h00, 1, 0, 3'b000, 27), 1, 27, 32'h12345678, 1);
        // ignored load opcode, slli with alt funct7 and srl with odd funct7
        add_row(encode_i(12'h004, 2, 3'b010, 1, 7'b0000011), 0, 0, 32'h0, 0);
        add_row(encode_i(12'h404, 2, 3'b001, 1, op_imm), 0, 0, 32'h0, 0);
        add_row(encode_r(7'h01, 16, 2, 3'b101, 2), 0, 0, 32'h0, 0);
        add_row(encode_i(12'h000, 1, 3'b000, 28, op_imm), 1, 28, 32'h12345678, 0);
        add_row(encode_r(7'h00, 0, 2, 3'b000, 29), 1, 29, 32'hdeadbeef, 0);
    endtask

    task automatic issue_rows();
        int gap;
        for (int i = 0; i < row_instr.size(); i++) begin
            if (row_b2b[i]) begin
                gap = 0;
            end else if (i > 0 && !row_has_result[i-1]) begin
                gap = 3; // keep the silent window clear of the next strobe
            end else begin
                gap = $urandom % 4;
            end
            repeat (gap) begin
                @(posedge clk);
                instr_valid <= 1'b0;
            end
            @(posedge clk);
            instr_valid <= 1'b1;
            instr       <= row_instr[i];
            due_q.push_back(cyc + 4); // sampled next edge and result two edges later
            idx_q.push_back(i);
        end
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    task automatic check_results();
        int  waited;
        int  row;
        int  due;
        int  errs_before;
        bit  seen;
        for (int n = 0; n < row_instr.size(); n++) begin
            waited = 0;
            while (due_q.size() == 0 && waited < 20) begin
                @(negedge clk);
                waited++;
            end
            if (due_q.size() == 0) begin
                $display("row %0d was never issued", n);
                errors++;
                rows_failed++;
                return;
            end
            row = idx_q.pop_front();
            due = due_q.pop_front();
            errs_before = errors;
            if (row_has_result[row]) begin
                waited = 0;
                seen   = 1'b0;
                while (!seen && waited < 10) begin
                    @(negedge clk);
                    waited++;
                    seen = wb_valid;
                end
                assert (seen) else begin
                    $display("row %0d: no result strobe within 10 cycles", row);
                    errors++;
                end
                if (seen) begin
                    assert (cyc == due) else begin
                        $display("row %0d: result strobe in cycle %0d instead of %0d",
                                 row, cyc, due);
                        errors++;
                    end
                    assert (wb_rd == row_rd[row]) else begin
                        $display("ERROR row %0d: wb_rd = %h, expected %h",
                                 row, wb_rd, row_rd[row]);
                        errors++;
                    end
                    assert (wb_data == row_data[row]) else begin
                        $display("ERROR row %0d: wb_data = %h, expected %h",
                                 row, wb_data, row_data[row]);
                        errors++;
                    end
                end
            end else begin
                waited = 0;
                while (cyc < due - 1 && waited < 10) begin
                    @(negedge clk);
                    waited++;
                end
                for (int c = 0; c < 3; c++) begin
                    @(negedge clk);
                    assert (!wb_valid) else begin
                        $display("row %0d: unexpected result strobe for an ignored instruction",
                                 row);
                        errors++;
                    end
                end
            end
            if (errors == errs_before) begin
                $display("row %0d ok", row);
                rows_passed++;
            end else begin
                $display("row %0d failed", row);
                rows_failed++;
            end
        end
    endtask

    task automatic check_idle();
        for (int c = 0; c < 6; c++) begin
            @(negedge clk);
            assert (!wb_valid) else begin
                $display("unexpected result strobe after the last row");
                errors++;
            end
        end
    endtask

    initial begin
        int waited;
        instr_valid <= 1'b0;
        instr       <= '0;
        void'($urandom(32'h2a7145e9));
        fill_table();
        waited = 0;
        while (!reset && waited < 40) begin
            @(posedge clk);
            waited++;
        end
        assert (reset) else begin
            $display("reset was never released");
            errors++;
        end
        fork
            issue_rows();
            check_results();
        join
        check_idle();
        $display("rows %0d, passed %0d, failed %0d, errors %0d",
                 row_instr.size(), rows_passed, rows_failed, errors);
        if (errors == 0 && rows_failed == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // overall limit on run length
    initial begin
        repeat (2000) @(posedge clk);
        $display("simulation timed out");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic reset
);

    localparam int half_period  = 4;
    localparam int reset_cycles = 16;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        reset = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b1;
    end

endmodule
